// ==== design/arm_isa_pkg.sv ====
package arm_isa_pkg;

	// Condition field, bits 31:28.
	typedef enum logic [3:0] {
		COND_EQ = 4'h0,	// Z set.
		COND_NE = 4'h1,
		COND_CS = 4'h2,	// Carry set.
		COND_CC = 4'h3,
		COND_MI = 4'h4,
		COND_PL = 4'h5,
		COND_VS = 4'h6,
		COND_VC = 4'h7,
		COND_HI = 4'h8,	// Unsigned higher.
		COND_LS = 4'h9,
		COND_GE = 4'ha,	// Signed compares.
		COND_LT = 4'hb,
		COND_GT = 4'hc,
		COND_LE = 4'hd,
		COND_AL = 4'he,
		COND_NV = 4'hf	// Never executes here.
	} cond_t;

	// Data processing opcode, bits 24:21.
	typedef enum logic [3:0] {
		ALU_AND = 4'h0,
		ALU_EOR = 4'h1,
		ALU_SUB = 4'h2,
		ALU_RSB = 4'h3,
		ALU_ADD = 4'h4,
		ALU_ADC = 4'h5,
		ALU_SBC = 4'h6,
		ALU_RSC = 4'h7,
		ALU_TST = 4'h8,
		ALU_TEQ = 4'h9,
		ALU_CMP = 4'ha,
		ALU_CMN = 4'hb,
		ALU_ORR = 4'hc,
		ALU_MOV = 4'hd,
		ALU_BIC = 4'he,
		ALU_MVN = 4'hf
	} alu_op_t;

	// Shift type of a register operand, bits 6:5.
	typedef enum logic [1:0] {
		SHIFT_LSL = 2'd0,
		SHIFT_LSR = 2'd1,
		SHIFT_ASR = 2'd2,
		SHIFT_ROR = 2'd3	// ROR #0 means RRX.
	} shift_t;

	localparam int CPSR_N = 31;
	localparam int CPSR_Z = 30;
	localparam int CPSR_C = 29;
	localparam int CPSR_V = 28;

	// Seventeen classes, so the encoding needs five bits.
	typedef enum logic [4:0] {
		MUL,
		MRS,
		MSR_REG,
		MSR_FLAGS,
		ALU,
		SWAP,
		BX,
		HALF_REG,
		HALF_IMM,
		UNDEF,
		SDT,
		BDT,
		BRANCH,
		CP_TRANS,	// Coprocessor load and store.
		CP_DATA,
		CP_REG,
		SWI
	} insn_class_t;

endpackage

// ==== design/pipe_pkg.sv ====
package pipe_pkg;

	// First fetch address after reset.
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	// Cycles from issue until the destination registers and flags
	// are free again. Stands in for execute and writeback.
	localparam int WB_LATENCY = 3;

	// Fetch side bus state.
	typedef enum logic {
		IDLE = 1'b0,	// No cycle on the bus.
		BUS = 1'b1	// Waiting for ack.
	} fetch_state_t;

endpackage

// ==== design/insn_fetch.sv ====
`timescale 1ns/1ps

module insn_fetch import pipe_pkg::*; (
	input logic clk,
	input logic reset,

	// Wishbone classic read master.
	output logic wb_cyc,
	output logic wb_stb,
	output logic [31:0] wb_adr,
	input logic [31:0] wb_dat_r,
	input logic wb_ack,

	// One word buffer towards issue.
	input logic buf_take,
	output logic buf_valid,
	output logic [31:0] buf_insn,
	output logic [31:0] buf_pc
);

	fetch_state_t state;
	logic [31:0] pc;	// Address of the next word to read.
	logic done;

	assign wb_cyc = (state == BUS);
	assign wb_stb = (state == BUS);
	assign wb_adr = pc;	// Only moves after ack, so steady during a cycle.

	assign done = (state == BUS) && wb_ack;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			pc <= RESET_PC;
		end
		else
		begin
			case (state)
			IDLE:
				if (!buf_valid || buf_take)
					state <= BUS;
			BUS:
				if (wb_ack)
				begin
					state <= IDLE;
					pc <= pc + 32'd4;
				end
			default:
				state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			buf_valid <= 1'b0;
		else if (done)
			buf_valid <= 1'b1;
		else if (buf_take)
			buf_valid <= 1'b0;
	end

	// Word and its address are captured on the ack edge.
	always_ff @(posedge clk)
	begin
		if (done)
		begin
			buf_insn <= wb_dat_r;
			buf_pc <= pc;
		end
	end

endmodule

// ==== design/issue_decode.sv ====
`timescale 1ns/1ps

module issue_decode import arm_isa_pkg::*; (
	input logic [31:0] insn,
	output insn_class_t insn_class,
	output logic [15:0] use_regs,
	output logic [15:0] def_regs,
	output logic use_flags,
	output logic def_flags
);

	logic [3:0] rn;
	logic [3:0] rd;
	logic [3:0] rs;
	logic [3:0] rm;
	cond_t cond;
	alu_op_t alu_op;
	shift_t shift_type;
	logic flag_read;	// Flag reads other than the condition.

	// One-hot mask of a register, r15 never counts.
	function automatic logic [15:0] reg_bit(input logic [3:0] r);
		if (r == 4'd15)
			return 16'h0000;
		return 16'h0001 << r;
	endfunction

	function automatic logic is_logical(input alu_op_t op);
		case (op)
		ALU_AND, ALU_EOR, ALU_TST, ALU_TEQ, ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN:
			return 1'b1;
		default:
			return 1'b0;
		endcase
	endfunction

	function automatic logic is_compare(input alu_op_t op);
		return (op == ALU_TST) || (op == ALU_TEQ) || (op == ALU_CMP) || (op == ALU_CMN);
	endfunction

	assign rn = insn[19:16];
	assign rd = insn[15:12];
	assign rs = insn[11:8];
	assign rm = insn[3:0];
	assign cond = cond_t'(insn[31:28]);
	assign alu_op = alu_op_t'(insn[24:21]);
	assign shift_type = shift_t'(insn[6:5]);

	always_comb
	begin
		insn_class = UNDEF;
		use_regs = 16'h0000;
		def_regs = 16'h0000;
		flag_read = 1'b0;
		def_flags = 1'b0;
		// Specific patterns inside the ALU space come first.
		casez (insn)
		32'b????_0000_00??_????_????_????_1001_????:
		begin
			insn_class = MUL;
			// Rd sits in 19:16 and the accumulator in 15:12 here.
			use_regs = (insn[21] ? reg_bit(rd) : 16'h0000) | reg_bit(rs) | reg_bit(rm);
			def_regs = reg_bit(rn);
			def_flags = insn[20];
		end
		32'b????_0001_0?00_1111_????_0000_0000_0000:
		begin
			insn_class = MRS;
			def_regs = reg_bit(rd);
			flag_read = !insn[22];	// Source is the CPSR.
		end
		32'b????_0001_0?10_1001_1111_0000_0000_????:
		begin
			insn_class = MSR_REG;
			use_regs = reg_bit(rm);
			def_flags = 1'b1;
		end
		32'b????_00?1_0?10_1000_1111_????_????_????:
		begin
			insn_class = MSR_FLAGS;
			use_regs = insn[25] ? 16'h0000 : reg_bit(rm);
			def_flags = 1'b1;
		end
		32'b????_0001_0?00_????_????_0000_1001_????:
		begin
			insn_class = SWAP;
			use_regs = reg_bit(rn) | reg_bit(rm);
			def_regs = reg_bit(rd);
		end
		32'b????_0001_0010_1111_1111_1111_0001_????:
		begin
			insn_class = BX;
			use_regs = reg_bit(rm);
		end
		32'b????_000?_?0??_????_????_0000_1??1_????:
		begin
			insn_class = HALF_REG;
			use_regs = reg_bit(rn) | reg_bit(rm) | (insn[20] ? 16'h0000 : reg_bit(rd));
			def_regs = insn[20] ? reg_bit(rd) : 16'h0000;
		end
		32'b????_000?_?1??_????_????_????_1??1_????:
		begin
			insn_class = HALF_IMM;
			use_regs = reg_bit(rn) | (insn[20] ? 16'h0000 : reg_bit(rd));
			def_regs = insn[20] ? reg_bit(rd) : 16'h0000;
		end
		32'b????_00??_????_????_????_????_????_????:
		begin
			insn_class = ALU;
			if (!insn[25])
				use_regs = insn[4] ? (reg_bit(rs) | reg_bit(rm)) : reg_bit(rm);
			if ((alu_op != ALU_MOV) && (alu_op != ALU_MVN))
				use_regs = use_regs | reg_bit(rn);
			def_regs = is_compare(alu_op) ? 16'h0000 : reg_bit(rd);
			// LSL #0 and RRX pass the carry through.
			flag_read = !insn[25] && !insn[4] && (insn[11:7] == 5'd0) &&
				((shift_type == SHIFT_LSL) || (shift_type == SHIFT_ROR));
			def_flags = insn[20] || is_logical(alu_op);
		end
		32'b????_011?_????_????_????_????_???1_????:
			insn_class = UNDEF;
		32'b????_01??_????_????_????_????_????_????:
		begin
			insn_class = SDT;
			use_regs = reg_bit(rn) | (insn[20] ? 16'h0000 : reg_bit(rd));
			if (!insn[25])
				use_regs = use_regs | reg_bit(rm);
			def_regs = (insn[20] ? reg_bit(rd) : 16'h0000) | (insn[21] ? reg_bit(rn) : 16'h0000);
		end
		32'b????_100?_????_????_????_????_????_????:
		begin
			insn_class = BDT;
			use_regs = reg_bit(rn) | (insn[20] ? 16'h0000 : (insn[15:0] & 16'h7fff));
			def_regs = (insn[21] ? reg_bit(rn) : 16'h0000) |
				(insn[20] ? (insn[15:0] & 16'h7fff) : 16'h0000);
			def_flags = insn[22];	// Covers the LDM with CPSR restore.
		end
		32'b????_101?_????_????_????_????_????_????:
			insn_class = BRANCH;
		32'b????_110?_????_????_????_????_????_????:
		begin
			insn_class = CP_TRANS;
			use_regs = reg_bit(rn);
			def_regs = insn[21] ? reg_bit(rn) : 16'h0000;
		end
		32'b????_1110_????_????_????_????_???0_????:
			insn_class = CP_DATA;
		32'b????_1110_????_????_????_????_???1_????:
		begin
			insn_class = CP_REG;
			use_regs = insn[20] ? 16'h0000 : reg_bit(rd);
			def_regs = insn[20] ? reg_bit(rd) : 16'h0000;
		end
		32'b????_1111_????_????_????_????_????_????:
			insn_class = SWI;
		default:
			insn_class = UNDEF;
		endcase
		use_flags = (insn_class != UNDEF) && ((cond != COND_AL) || flag_read);
	end

endmodule

// ==== design/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage import arm_isa_pkg::*, pipe_pkg::*; (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic [31:0] cpsr,

	input logic buf_valid,
	input logic [31:0] buf_insn,
	input logic [31:0] buf_pc,
	output logic buf_take,

	output logic issue_valid,
	output logic [31:0] issue_pc,
	output logic [31:0] issue_insn,
	output insn_class_t issue_class,
	output logic issue_exec
);

	insn_class_t dec_class;
	logic [15:0] dec_use_regs;
	logic [15:0] dec_def_regs;
	logic dec_use_flags;
	logic dec_def_flags;
	logic cond_pass;
	logic hazard;
	logic [WB_LATENCY-1:0][15:0] rsv_regs;	// Newest entry at index 0.
	logic [WB_LATENCY-1:0] rsv_flags;
	logic [15:0] reserved_regs;

	issue_decode issue_decode_i (
		.insn (buf_insn),
		.insn_class (dec_class),
		.use_regs (dec_use_regs),
		.def_regs (dec_def_regs),
		.use_flags (dec_use_flags),
		.def_flags (dec_def_flags)
	);

	always_comb
	begin
		cond_pass = 1'b0;
		case (cond_t'(buf_insn[31:28]))
		COND_EQ: cond_pass = cpsr[CPSR_Z];
		COND_NE: cond_pass = !cpsr[CPSR_Z];
		COND_CS: cond_pass = cpsr[CPSR_C];
		COND_CC: cond_pass = !cpsr[CPSR_C];
		COND_MI: cond_pass = cpsr[CPSR_N];
		COND_PL: cond_pass = !cpsr[CPSR_N];
		COND_VS: cond_pass = cpsr[CPSR_V];
		COND_VC: cond_pass = !cpsr[CPSR_V];
		COND_HI: cond_pass = cpsr[CPSR_C] && !cpsr[CPSR_Z];
		COND_LS: cond_pass = !cpsr[CPSR_C] || cpsr[CPSR_Z];
		COND_GE: cond_pass = (cpsr[CPSR_N] == cpsr[CPSR_V]);
		COND_LT: cond_pass = (cpsr[CPSR_N] != cpsr[CPSR_V]);
		COND_GT: cond_pass = !cpsr[CPSR_Z] && (cpsr[CPSR_N] == cpsr[CPSR_V]);
		COND_LE: cond_pass = cpsr[CPSR_Z] || (cpsr[CPSR_N] != cpsr[CPSR_V]);
		COND_AL: cond_pass = 1'b1;
		COND_NV: cond_pass = 1'b0;
		endcase
	end

	// Reserved set is everything still in flight.
	always_comb
	begin
		reserved_regs = 16'h0000;
		for (int i = 0; i < WB_LATENCY; i++)
			reserved_regs = reserved_regs | rsv_regs[i];
	end

	assign hazard = (|(dec_use_regs & reserved_regs)) || (dec_use_flags && (|rsv_flags));
	assign buf_take = buf_valid && !hazard && !stall;

	// Entries fall off the end WB_LATENCY edges after issue.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rsv_regs <= '0;
			rsv_flags <= '0;
		end
		else
		begin
			for (int i = WB_LATENCY - 1; i > 0; i--)
			begin
				rsv_regs[i] <= rsv_regs[i - 1];
				rsv_flags[i] <= rsv_flags[i - 1];
			end
			rsv_regs[0] <= (buf_take && cond_pass) ? dec_def_regs : 16'h0000;
			rsv_flags[0] <= buf_take && cond_pass && dec_def_flags;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			issue_valid <= 1'b0;
		else
			issue_valid <= buf_take;
	end

	always_ff @(posedge clk)
	begin
		if (buf_take)
		begin
			issue_pc <= buf_pc;
			issue_insn <= buf_insn;
			issue_class <= dec_class;
			issue_exec <= cond_pass;	// Failed condition still issues.
		end
	end

endmodule

// ==== design/arm_issue_top.sv ====
`timescale 1ns/1ps

module arm_issue_top import arm_isa_pkg::*; (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic [31:0] cpsr,

	output logic wb_cyc,
	output logic wb_stb,
	output logic [31:0] wb_adr,
	input logic [31:0] wb_dat_r,
	input logic wb_ack,

	output logic issue_valid,
	output logic [31:0] issue_pc,
	output logic [31:0] issue_insn,
	output insn_class_t issue_class,
	output logic issue_exec
);

	logic buf_valid;
	logic [31:0] buf_insn;
	logic [31:0] buf_pc;
	logic buf_take;

	insn_fetch insn_fetch_i (
		.clk (clk),
		.reset (reset),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_adr (wb_adr),
		.wb_dat_r (wb_dat_r),
		.wb_ack (wb_ack),
		.buf_take (buf_take),
		.buf_valid (buf_valid),
		.buf_insn (buf_insn),
		.buf_pc (buf_pc)
	);

	issue_stage issue_stage_i (
		.clk (clk),
		.reset (reset),
		.stall (stall),
		.cpsr (cpsr),
		.buf_valid (buf_valid),
		.buf_insn (buf_insn),
		.buf_pc (buf_pc),
		.buf_take (buf_take),
		.issue_valid (issue_valid),
		.issue_pc (issue_pc),
		.issue_insn (issue_insn),
		.issue_class (issue_class),
		.issue_exec (issue_exec)
	);

endmodule

// ==== dv/arm_issue_properties.sv ====
`timescale 1ns/1ps

module arm_issue_properties (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic wb_cyc,
	input logic wb_stb,
	input logic [31:0] wb_adr,
	input logic wb_ack,
	input logic issue_valid
);

	// Strobe only inside a bus cycle.
	assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
		else $error("wb_stb high without wb_cyc");

	// Request held until the slave answers.
	assert property (@(posedge clk) disable iff (reset)
		(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
		else $error("wb_stb or wb_adr changed before wb_ack");

	assert property (@(posedge clk) reset |=> !issue_valid)
		else $error("issue_valid high in the cycle after reset");

	// A stalled cycle never issues.
	assert property (@(posedge clk) disable iff (reset) stall |=> !issue_valid)
		else $error("issue_valid high in the cycle after stall");

endmodule

// ==== dv/arm_issue_tb.sv ====
`timescale 1ns/1ps

module arm_issue_tb import arm_isa_pkg::*, pipe_pkg::*; ();

	logic clk = 1'b0;
	logic reset;
	logic stall;
	logic [31:0] cpsr;
	logic wb_cyc;
	logic wb_stb;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic issue_valid;
	logic [31:0] issue_pc;
	logic [31:0] issue_insn;
	insn_class_t issue_class;
	logic issue_exec;

	logic [31:0] mem [0:255];	// Program memory.
	logic [31:0] seed;
	logic [1:0] wait_left;
	int issued = 0;
	int delivered = 0;	// Completed bus reads.
	int prev_delivered = 0;
	logic last_reset = 1'b1;	// Inputs as seen by the last edge.
	logic last_stall = 1'b0;
	logic [31:0] last_cpsr = '0;
	logic [15:0] rsv_r [WB_LATENCY];
	logic rsv_f [WB_LATENCY];

	arm_issue_top arm_issue_top_i (
		.clk (clk),
		.reset (reset),
		.stall (stall),
		.cpsr (cpsr),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_adr (wb_adr),
		.wb_dat_r (wb_dat_r),
		.wb_ack (wb_ack),
		.issue_valid (issue_valid),
		.issue_pc (issue_pc),
		.issue_insn (issue_insn),
		.issue_class (issue_class),
		.issue_exec (issue_exec)
	);

	bind arm_issue_top arm_issue_properties arm_issue_properties_i (
		.clk (clk),
		.reset (reset),
		.stall (stall),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_adr (wb_adr),
		.wb_ack (wb_ack),
		.issue_valid (issue_valid)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp)
		begin
			$display("ERR %0t: %s expected %h, got %h", $time, what, exp, got);
			abort_run();
		end
	endtask

	task automatic check_class(input string what, input insn_class_t exp, input insn_class_t got);
		if (got !== exp)
		begin
			$display("ERR %0t: %s expected %s, got %s", $time, what, exp.name(), got.name());
			abort_run();
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic got);
		if (got !== exp)
		begin
			$display("ERR %0t: %s expected %b, got %b", $time, what, exp, got);
			abort_run();
		end
	endtask

	// Even codes test a flag expression and odd codes invert it.
	function automatic logic cond_holds(input logic [3:0] c, input logic [31:0] p);
		logic n;
		logic z;
		logic cf;
		logic v;
		logic base;
		n = p[CPSR_N];
		z = p[CPSR_Z];
		cf = p[CPSR_C];
		v = p[CPSR_V];
		case (c[3:1])
		3'd0: base = z;
		3'd1: base = cf;
		3'd2: base = n;
		3'd3: base = v;
		3'd4: base = cf && !z;
		3'd5: base = (n == v);
		3'd6: base = !z && (n == v);
		default: base = 1'b1;	// AL here and NV by inversion.
		endcase
		return c[0] ? !base : base;
	endfunction

	function automatic logic [15:0] onehot(input logic [3:0] r);
		return 16'h0001 << r;
	endfunction

	function automatic insn_class_t classify(input logic [31:0] w, output logic [15:0] use_r,
		output logic [15:0] def_r, output logic use_f, output logic def_f);
		insn_class_t c;
		logic rd_flags;
		logic logical;
		logic [15:0] rn;
		logic [15:0] rd;
		logic [15:0] rs;
		logic [15:0] rm;
		logic [3:0] op;
		rn = onehot(w[19:16]);
		rd = onehot(w[15:12]);
		rs = onehot(w[11:8]);
		rm = onehot(w[3:0]);
		op = w[24:21];
		use_r = '0;
		def_r = '0;
		rd_flags = 1'b0;
		def_f = 1'b0;
		c = UNDEF;
		if ((w[27:22] == 6'b000000) && (w[7:4] == 4'b1001))
		begin
			c = MUL;
			use_r = rs | rm | (w[21] ? rd : '0);	// Accumulate adds Rn field at 15:12.
			def_r = rn;
			def_f = w[20];
		end
		else if ((w[27:23] == 5'b00010) && (w[21:16] == 6'b001111) && (w[11:0] == 12'h000))
		begin
			c = MRS;
			def_r = rd;
			rd_flags = !w[22];
		end
		else if ((w[27:23] == 5'b00010) && (w[21:4] == 18'b10_1001_1111_0000_0000))
		begin
			c = MSR_REG;
			use_r = rm;
			def_f = 1'b1;
		end
		else if ((w[27:26] == 2'b00) && (w[24:23] == 2'b10) && (w[21:12] == 10'b10_1000_1111))
		begin
			c = MSR_FLAGS;
			use_r = w[25] ? '0 : rm;
			def_f = 1'b1;
		end
		else if ((w[27:23] == 5'b00010) && (w[21:20] == 2'b00) && (w[11:4] == 8'h09))
		begin
			c = SWAP;
			use_r = rn | rm;
			def_r = rd;
		end
		else if (w[27:4] == 24'h12fff1)
		begin
			c = BX;
			use_r = rm;
		end
		else if ((w[27:25] == 3'b000) && w[7] && w[4] && (w[22] || (w[11:8] == 4'd0)))
		begin
			c = w[22] ? HALF_IMM : HALF_REG;
			use_r = rn | (w[20] ? '0 : rd) | (w[22] ? '0 : rm);
			def_r = w[20] ? rd : '0;
		end
		else if (w[27:26] == 2'b00)
		begin
			c = ALU;
			if (!w[25])
				use_r = w[4] ? (rs | rm) : rm;
			if ((op != 4'hd) && (op != 4'hf))
				use_r = use_r | rn;	// MOV and MVN ignore Rn.
			def_r = (op[3:2] == 2'b10) ? '0 : rd;
			rd_flags = !w[25] && !w[4] && (w[11:7] == 5'd0) && (w[6] == w[5]);
			logical = op[3] ? (op[3:1] != 3'b101) : (op[3:1] == 3'b000);
			def_f = w[20] || logical;
		end
		else if ((w[27:25] == 3'b011) && w[4])
			c = UNDEF;
		else if (w[27:26] == 2'b01)
		begin
			c = SDT;
			use_r = rn | (w[20] ? '0 : rd) | (w[25] ? '0 : rm);
			def_r = (w[20] ? rd : '0) | (w[21] ? rn : '0);
		end
		else if (w[27:25] == 3'b100)
		begin
			c = BDT;
			use_r = rn | (w[20] ? '0 : w[15:0]);
			def_r = (w[21] ? rn : '0) | (w[20] ? w[15:0] : '0);
			def_f = w[22];
		end
		else if (w[27:25] == 3'b101)
			c = BRANCH;
		else if (w[27:25] == 3'b110)
		begin
			c = CP_TRANS;
			use_r = rn;
			def_r = w[21] ? rn : '0;
		end
		else if (w[27:24] == 4'he)
		begin
			c = w[4] ? CP_REG : CP_DATA;
			if (w[4])
			begin
				use_r = w[20] ? '0 : rd;
				def_r = w[20] ? rd : '0;
			end
		end
		else
			c = SWI;
		use_r = use_r & 16'h7fff;	// PC never tracked.
		def_r = def_r & 16'h7fff;
		use_f = (c != UNDEF) && ((w[31:28] != 4'he) || rd_flags);
		return c;
	endfunction

	// Input driver and bus responder.
	always @(posedge clk)
	begin
		logic [31:0] r;
		last_reset = reset;
		last_stall = stall;
		last_cpsr = cpsr;
		prev_delivered = delivered;
		if (reset)
			delivered = 0;
		else if (wb_cyc && wb_ack)
			delivered = delivered + 1;
		r = next_random();
		stall <= (r[25:24] == 2'b00);
		cpsr <= next_random();
		if (wb_ack)
		begin
			wb_ack <= 1'b0;
			wait_left = r[21:20];	// Delay for the next request.
		end
		else if (wb_cyc && wb_stb)
		begin
			if (wait_left == 2'd0)
			begin
				wb_ack <= 1'b1;
				wb_dat_r <= mem[wb_adr[9:2]];
			end
			else
				wait_left = wait_left - 2'd1;
		end
	end

	// Reference model runs mid-cycle for the edge just passed.
	always @(negedge clk)
	begin
		insn_class_t cls;
		logic [15:0] use_r;
		logic [15:0] def_r;
		logic [15:0] reserved;
		logic use_f;
		logic def_f;
		logic flags_busy;
		logic held;
		logic exec;
		logic expect_issue;
		logic [31:0] word;
		if (last_reset)
		begin
			issued = 0;
			for (int i = 0; i < WB_LATENCY; i++)
			begin
				rsv_r[i] = '0;
				rsv_f[i] = 1'b0;
			end
			check_bit("issue_valid in reset", 1'b0, issue_valid);
		end
		else
		begin
			word = mem[issued[7:0]];
			cls = classify(word, use_r, def_r, use_f, def_f);
			reserved = '0;
			flags_busy = 1'b0;
			for (int i = 0; i < WB_LATENCY; i++)
			begin
				reserved = reserved | rsv_r[i];
				flags_busy = flags_busy | rsv_f[i];
			end
			held = (|(use_r & reserved)) || (use_f && flags_busy);
			expect_issue = (prev_delivered > issued) && !last_stall && !held;
			exec = cond_holds(word[31:28], last_cpsr);
			check_bit("issue_valid", expect_issue, issue_valid);
			if (expect_issue)
			begin
				check_word("issue_pc", RESET_PC + {issued[29:0], 2'b00}, issue_pc);
				check_word("issue_insn", word, issue_insn);
				check_class("issue_class", cls, issue_class);
				check_bit("issue_exec", exec, issue_exec);
				issued = issued + 1;
			end
			for (int i = WB_LATENCY - 1; i > 0; i--)
			begin
				rsv_r[i] = rsv_r[i - 1];
				rsv_f[i] = rsv_f[i - 1];
			end
			rsv_r[0] = (expect_issue && exec) ? def_r : '0;
			rsv_f[0] = expect_issue && exec && def_f;
		end
	end

	initial
	begin
		logic [31:0] r;
		int waited;
		logic timed_out;
		seed = 32'd51;
		reset <= 1'b1;
		stall <= 1'b0;
		cpsr <= '0;
		wb_ack <= 1'b0;
		wb_dat_r <= '0;
		wait_left = 2'd0;
		for (int i = 0; i < 256; i++)
		begin
			r = next_random() & 32'hffff_0000;
			r = r | (next_random() >> 16);
			if (next_random() & 32'h0001_0000)
				r[31:28] = 4'he;	// About half execute always.
			mem[i] = r;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		timed_out = 1'b0;
		for (int k = 0; (k < 200) && !timed_out; k++)
		begin
			waited = 0;
			while ((issued <= k) && (waited < 100))
			begin
				@(posedge clk);
				waited++;
			end
			if (issued <= k)
				timed_out = 1'b1;
		end
		if (timed_out)
		begin
			$display("Timeout: instruction %0d never issued", issued);
			abort_run();
		end
		else
		begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

// ==== arm_issue_top.f ====
design/arm_isa_pkg.sv
design/pipe_pkg.sv
design/insn_fetch.sv
design/issue_decode.sv
design/issue_stage.sv
design/arm_issue_top.sv
dv/arm_issue_properties.sv
dv/arm_issue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= arm_issue_tb
FILELIST ?= arm_issue_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
